// File: include/acq_timing_defines.svh
`ifndef ACQ_TIMING_DEFINES_SVH
`define ACQ_TIMING_DEFINES_SVH

////////////////////////////////////////////////////////////
// configuration field widths
////////////////////////////////////////////////////////////

// trigger delay, counted in sync ticks
`define TRIG_DELAY_W 12

// hold-off from window start to first stored sample
`define HOLD_OFF_W 7

// samples stored per acquisition
`define NUM_SMPLS_W 10

// sync tick period minus one, in fastClk cycles
`define SYNC_PERIOD_W 8

// store window counter, holds hold-off plus sample count
`define SAMPLE_CTR_W 11

////////////////////////////////////////////////////////////
// fixed phase lengths in fastClk cycles
////////////////////////////////////////////////////////////

// adc warm-up, roughly 9.24 us at a 2.8 ns clock
`define WARMUP_CYCLES 3300

// adc alignment phase
`define ALIGN_CYCLES 560

// shared warm-up / align phase counter
`define ALIGN_CTR_W 12

`endif

// File: design/acq_timing_pkg.sv
`include "acq_timing_defines.svh"

package acq_timing_pkg;

	////////////////////////////////////////////////////////////
	// sequencer state
	////////////////////////////////////////////////////////////

	// one-hot, one bit per phase of the acquisition
	typedef enum logic [3:0] {
		IDLE     = 4'b0001,
		WARM_UP  = 4'b0010,
		SAMPLING = 4'b0100,
		ALIGN    = 4'b1000
	} acq_state_t;

	////////////////////////////////////////////////////////////
	// configuration fields
	////////////////////////////////////////////////////////////

	// delay from trigger in sync ticks
	typedef logic [`TRIG_DELAY_W-1:0] trig_delay_t;

	// cycles from window start to store strobe
	typedef logic [`HOLD_OFF_W-1:0] hold_off_t;

	// length of the store strobe
	typedef logic [`NUM_SMPLS_W-1:0] num_smpls_t;

	// tick spacing minus one
	typedef logic [`SYNC_PERIOD_W-1:0] sync_period_t;

	////////////////////////////////////////////////////////////
	// counters
	////////////////////////////////////////////////////////////

	// store window position
	typedef logic [`SAMPLE_CTR_W-1:0] sample_ctr_t;

	// warm-up and align share this one
	typedef logic [`ALIGN_CTR_W-1:0] phase_ctr_t;

endpackage

// File: design/ring_clock_sync.sv
`include "acq_timing_defines.svh"

module ring_clock_sync (
	input  logic                         fastClk,
	input  logic                         arst_n,
	input  logic                         ring_clk,
	input  logic                         ring_edge_sel,
	input  logic                         use_ext_sync,
	input  acq_timing_pkg::sync_period_t sync_period,
	output logic                         sync_tick
);

	// two-flop synchroniser plus one history flop
	logic ring_a;
	logic ring_b;
	logic ring_c;

	// selected ring clock edge, one cycle wide
	logic ring_edge;

	// tick generator
	logic                         running;
	acq_timing_pkg::sync_period_t sync_cnt;

	////////////////////////////////////////////////////////////
	// ring clock synchroniser and edge select
	////////////////////////////////////////////////////////////

	always_ff @(posedge fastClk or negedge arst_n) begin
		if (!arst_n) begin
			ring_a <= 1'b0;
			ring_b <= 1'b0;
			ring_c <= 1'b0;
		end else begin
			// ring_a may go metastable, ring_b settles it
			ring_a <= ring_clk;
			ring_b <= ring_a;
			ring_c <= ring_b;
		end
	end

	// sel high -> rising edge, low -> falling edge
	assign ring_edge = ring_edge_sel ? (ring_b & ~ring_c) : (~ring_b & ring_c);

	////////////////////////////////////////////////////////////
	// sync tick generator
	////////////////////////////////////////////////////////////

	// start latch
	// ext mode waits for the first selected edge
	always_ff @(posedge fastClk or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
		end else if (!running) begin
			running <= use_ext_sync ? ring_edge : 1'b1;
		end
	end

	// free running divider once started
	always_ff @(posedge fastClk or negedge arst_n) begin
		if (!arst_n) begin
			sync_cnt  <= '0;
			sync_tick <= 1'b0;
		end else if (!running) begin
			sync_cnt  <= '0;
			sync_tick <= 1'b0;
		end else if (sync_cnt == sync_period) begin
			// wrap, tick lands one cycle later
			sync_cnt  <= '0;
			sync_tick <= 1'b1;
		end else begin
			sync_cnt  <= sync_cnt + 1'b1;
			sync_tick <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// period of at least two cycles gives isolated ticks
	a_tick_isolated : assert property (
		@(posedge fastClk) disable iff (!arst_n)
		(sync_tick && (sync_period != '0)) |=> !sync_tick
	) else $error("sync_tick high on two consecutive cycles");

endmodule

// File: design/acq_sequencer.sv
`include "acq_timing_defines.svh"

module acq_sequencer (
	input  logic                        fastClk,
	input  logic                        arst_n,
	input  logic                        trig,
	input  logic                        sync_tick,
	input  acq_timing_pkg::trig_delay_t trig_delay,
	input  acq_timing_pkg::hold_off_t   sample_hold_off,
	input  acq_timing_pkg::num_smpls_t  num_smpls,
	input  logic                        sampling_done,
	output logic                        sample_start,
	output acq_timing_pkg::hold_off_t   hold_off,
	output acq_timing_pkg::num_smpls_t  win_smpls,
	output logic                        adc_powerup,
	output logic                        adc_align_en,
	output acq_timing_pkg::acq_state_t  state
);

	// last count of each timed phase
	localparam acq_timing_pkg::phase_ctr_t WARMUP_LAST = `WARMUP_CYCLES - 1;
	localparam acq_timing_pkg::phase_ctr_t ALIGN_LAST  = `ALIGN_CYCLES - 1;

	// trigger seen, counting ticks in IDLE
	logic armed;
	logic arm_req;

	acq_timing_pkg::trig_delay_t delay_q;
	acq_timing_pkg::trig_delay_t tick_cnt;
	acq_timing_pkg::phase_ctr_t  phase_cnt;

	// only an idle, unarmed sequencer takes a trigger
	assign arm_req = (state == acq_timing_pkg::IDLE) && !armed && trig;

	////////////////////////////////////////////////////////////
	// configuration capture
	////////////////////////////////////////////////////////////

	// one set of values for the whole acquisition
	always_ff @(posedge fastClk) begin
		if (arm_req) begin
			delay_q   <= trig_delay;
			hold_off  <= sample_hold_off;
			win_smpls <= num_smpls;
		end
	end

	////////////////////////////////////////////////////////////
	// acquisition FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge fastClk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= acq_timing_pkg::IDLE;
			armed        <= 1'b0;
			tick_cnt     <= '0;
			phase_cnt    <= '0;
			sample_start <= 1'b0;
			adc_powerup  <= 1'b0;
			adc_align_en <= 1'b0;
		end else begin
			// start pulse is a single cycle
			sample_start <= 1'b0;
			case (state)
				acq_timing_pkg::IDLE: begin
					if (arm_req) begin
						armed    <= 1'b1;
						tick_cnt <= '0;
					end else if (armed && (tick_cnt == delay_q)) begin
						// delay reached, power the adc
						armed       <= 1'b0;
						state       <= acq_timing_pkg::WARM_UP;
						adc_powerup <= 1'b1;
						phase_cnt   <= '0;
					end else if (armed && sync_tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				acq_timing_pkg::WARM_UP: begin
					if (phase_cnt == WARMUP_LAST) begin
						// hand the window to store_window
						state        <= acq_timing_pkg::SAMPLING;
						sample_start <= 1'b1;
					end else begin
						phase_cnt <= phase_cnt + 1'b1;
					end
				end
				acq_timing_pkg::SAMPLING: begin
					// wait for the end of the store window
					if (sampling_done) begin
						state        <= acq_timing_pkg::ALIGN;
						adc_align_en <= 1'b1;
						phase_cnt    <= '0;
					end
				end
				acq_timing_pkg::ALIGN: begin
					if (phase_cnt == ALIGN_LAST) begin
						// align done, adc back off
						state        <= acq_timing_pkg::IDLE;
						adc_align_en <= 1'b0;
						adc_powerup  <= 1'b0;
					end else begin
						phase_cnt <= phase_cnt + 1'b1;
					end
				end
				default: begin
					// illegal encoding, recover to idle
					state        <= acq_timing_pkg::IDLE;
					armed        <= 1'b0;
					adc_align_en <= 1'b0;
					adc_powerup  <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	a_state_onehot : assert property (
		@(posedge fastClk) disable iff (!arst_n)
		$onehot(state)
	) else $error("sequencer state not one-hot");

	// align only ever runs on a powered adc
	a_align_powered : assert property (
		@(posedge fastClk) disable iff (!arst_n)
		adc_align_en |-> adc_powerup
	) else $error("adc_align_en high without adc_powerup");

endmodule

// File: design/store_window.sv
`include "acq_timing_defines.svh"

module store_window (
	input  logic                       fastClk,
	input  logic                       arst_n,
	input  logic                       sample_start,
	input  acq_timing_pkg::hold_off_t  hold_off,
	input  acq_timing_pkg::num_smpls_t win_smpls,
	output logic                       store_strb,
	output logic                       sampling_done
);

	// window running
	logic counting;

	acq_timing_pkg::sample_ctr_t sample_cnt;
	acq_timing_pkg::sample_ctr_t cnt_nxt;

	// window edges in counter units
	acq_timing_pkg::sample_ctr_t win_start;
	acq_timing_pkg::sample_ctr_t win_end;

	logic hit_start;
	logic hit_end;

	////////////////////////////////////////////////////////////
	// window compares
	////////////////////////////////////////////////////////////

	assign win_start = {{(`SAMPLE_CTR_W - `HOLD_OFF_W){1'b0}}, hold_off};
	assign win_end   = win_start + {{(`SAMPLE_CTR_W - `NUM_SMPLS_W){1'b0}}, win_smpls};

	// start pulse restarts from zero
	assign cnt_nxt = sample_start ? '0 : sample_cnt + 1'b1;

	// compare against the value being loaded
	// so the strobe lines up with the count
	assign hit_start = (cnt_nxt == win_start);
	assign hit_end   = (cnt_nxt == win_end);

	////////////////////////////////////////////////////////////
	// sample counter and strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge fastClk or negedge arst_n) begin
		if (!arst_n) begin
			counting      <= 1'b0;
			sample_cnt    <= '0;
			store_strb    <= 1'b0;
			sampling_done <= 1'b0;
		end else begin
			sampling_done <= 1'b0;
			if (sample_start || counting) begin
				sample_cnt <= cnt_nxt;
				if (hit_end) begin
					// end wins, covers a zero sample count
					counting      <= 1'b0;
					store_strb    <= 1'b0;
					sampling_done <= 1'b1;
				end else begin
					counting <= 1'b1;
					if (hit_start) begin
						store_strb <= 1'b1;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// strobe lives strictly inside the counting window
	a_strb_in_window : assert property (
		@(posedge fastClk) disable iff (!arst_n)
		store_strb |-> counting
	) else $error("store_strb high outside the store window");

endmodule

// File: design/acq_timing_top.sv
`include "acq_timing_defines.svh"

module acq_timing_top (
	input  logic                         fastClk,
	input  logic                         arst_n,
	input  logic                         ring_clk,
	input  logic                         ring_edge_sel,
	input  logic                         use_ext_sync,
	input  acq_timing_pkg::sync_period_t sync_period,
	input  logic                         trig,
	input  acq_timing_pkg::trig_delay_t  trig_delay,
	input  acq_timing_pkg::hold_off_t    sample_hold_off,
	input  acq_timing_pkg::num_smpls_t   num_smpls,
	output logic                         sync_tick,
	output logic                         adc_powerup,
	output logic                         adc_align_en,
	output logic                         store_strb,
	output acq_timing_pkg::acq_state_t   state
);

	// sequencer to store window
	logic                       sample_start;
	acq_timing_pkg::hold_off_t  hold_off;
	acq_timing_pkg::num_smpls_t win_smpls;

	// store window back to sequencer
	logic sampling_done;

	////////////////////////////////////////////////////////////
	// ring clock edges into sync ticks
	////////////////////////////////////////////////////////////

	ring_clock_sync ring_clock_sync_i (
		.fastClk       (fastClk),
		.arst_n        (arst_n),
		.ring_clk      (ring_clk),
		.ring_edge_sel (ring_edge_sel),
		.use_ext_sync  (use_ext_sync),
		.sync_period   (sync_period),
		.sync_tick     (sync_tick)
	);

	////////////////////////////////////////////////////////////
	// acquisition sequencer
	////////////////////////////////////////////////////////////

	acq_sequencer acq_sequencer_i (
		.fastClk         (fastClk),
		.arst_n          (arst_n),
		.trig            (trig),
		.sync_tick       (sync_tick),
		.trig_delay      (trig_delay),
		.sample_hold_off (sample_hold_off),
		.num_smpls       (num_smpls),
		.sampling_done   (sampling_done),
		.sample_start    (sample_start),
		.hold_off        (hold_off),
		.win_smpls       (win_smpls),
		.adc_powerup     (adc_powerup),
		.adc_align_en    (adc_align_en),
		.state           (state)
	);

	////////////////////////////////////////////////////////////
	// store strobe window
	////////////////////////////////////////////////////////////

	store_window store_window_i (
		.fastClk       (fastClk),
		.arst_n        (arst_n),
		.sample_start  (sample_start),
		.hold_off      (hold_off),
		.win_smpls     (win_smpls),
		.store_strb    (store_strb),
		.sampling_done (sampling_done)
	);

endmodule

// File: verif/tb_acq_timing.sv
`include "acq_timing_defines.svh"

module tb_acq_timing;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	// two synchroniser flops plus the edge flop
	localparam int EDGE_LATENCY = 3;
	// tick counted on its closing edge and state moving on the next one
	localparam int TICK_TO_POWERUP = 2;
	localparam int QUIET_CYCLES    = 30;
	// resets, sync tests and idle gaps between acquisitions
	localparam int SETUP_CYCLES    = 1000;

	// acquisition runs use internal sync ticks every 10 cycles
	localparam int ACQ_SYNC_PERIOD = 9;
	localparam int NUM_ACQ         = 4;
	localparam int ACQ_DELAY [NUM_ACQ] = '{3, 5, 2, 4};
	localparam int ACQ_HOLD  [NUM_ACQ] = '{5, 40, 10, 0};
	localparam int ACQ_SMPLS [NUM_ACQ] = '{20, 100, 30, 7};

	logic                         fastClk;
	logic                         arst_n;
	logic                         ring_clk;
	logic                         ring_edge_sel;
	logic                         use_ext_sync;
	acq_timing_pkg::sync_period_t sync_period;
	logic                         trig;
	acq_timing_pkg::trig_delay_t  trig_delay;
	acq_timing_pkg::hold_off_t    sample_hold_off;
	acq_timing_pkg::num_smpls_t   num_smpls;
	logic                         sync_tick;
	logic                         adc_powerup;
	logic                         adc_align_en;
	logic                         store_strb;
	acq_timing_pkg::acq_state_t   state;

	int     errors;
	int     tests_run;
	integer seed;

	acq_timing_top dut_i (.*);

	initial begin
		fastClk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) fastClk = ~fastClk;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// slack-padded length of one acquisition in cycles
	function automatic int acq_cycles(input int idx);
		return (ACQ_DELAY[idx] + 1) * (ACQ_SYNC_PERIOD + 1) + `WARMUP_CYCLES
			+ ACQ_HOLD[idx] + ACQ_SMPLS[idx] + `ALIGN_CYCLES + 16;
	endfunction

	task automatic log_mismatch(input string test, input string what, input int expected,
		input int actual);
		errors++;
		$display("[FAIL] %s: %s expected %0d actual %0d", test, what, expected, actual);
	endtask

	task automatic raise_error(input string msg);
		errors++;
		$display("ERROR: %s", msg);
	endtask

	task automatic apply_reset(input logic ext, input logic sel, input int period);
		@(negedge fastClk);
		arst_n        = 1'b0;
		use_ext_sync  = ext;
		ring_edge_sel = sel;
		sync_period   = acq_timing_pkg::sync_period_t'(period);
		ring_clk      = 1'b0;
		trig          = 1'b0;
		repeat (RESET_CYCLES) @(negedge fastClk);
		arst_n = 1'b1;
	endtask

	// random half periods of 3 to 10 cycles
	task automatic toggle_ring(input int edges);
		int half;
		for (int i = 0; i < edges; i++) begin
			half = 3 + ($random(seed) & 7);
			repeat (half) @(negedge fastClk);
			ring_clk = ~ring_clk;
		end
	endtask

	// count falling edges until sync_tick is seen or the limit is reached
	task automatic wait_tick(input int limit, output int cycles, output bit found);
		found  = 1'b0;
		cycles = 0;
		while (!found && cycles < limit) begin
			@(negedge fastClk);
			cycles++;
			found = (sync_tick === 1'b1);
		end
	endtask

	task automatic measure_tick_spacing(input string test, input int period, input int count);
		int gap;
		bit found;
		// first tick only anchors the count
		wait_tick(2 * (period + 1) + 4, gap, found);
		for (int i = 0; i < count && found; i++) begin
			wait_tick(2 * (period + 1) + 4, gap, found);
			if (found && gap != period + 1) begin
				log_mismatch(test, "sync_tick spacing", period + 1, gap);
			end
		end
		if (!found) begin
			raise_error({test, ": sync_tick stopped while measuring its spacing"});
		end
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		tests_run++;
		apply_reset(1'b0, 1'b1, 6);
		if (state !== acq_timing_pkg::IDLE) begin
			log_mismatch("reset_state", "state", int'(acq_timing_pkg::IDLE), int'(state));
		end
		if ({adc_powerup, adc_align_en, store_strb, sync_tick} !== 4'b0000) begin
			log_mismatch("reset_state", "outputs low", 0,
				int'({adc_powerup, adc_align_en, store_strb, sync_tick}));
		end
		// internal mode runs straight after reset
		measure_tick_spacing("reset_state", 6, 5);
	endtask

	task automatic check_ext_sync(input logic sel, input int period);
		string name;
		int    cycles;
		bit    found;
		name = sel ? "ext_sync_rise" : "ext_sync_fall";
		tests_run++;
		apply_reset(1'b1, sel, period);
		wait_tick(QUIET_CYCLES, cycles, found);
		if (found) begin
			raise_error({name, ": sync_tick appeared with no ring clock edge"});
		end
		if (!sel) begin
			// rising edge is the wrong one here
			@(negedge fastClk);
			ring_clk = 1'b1;
			wait_tick(QUIET_CYCLES, cycles, found);
			if (found) begin
				raise_error({name, ": sync_tick started on the unselected edge"});
			end
		end
		@(negedge fastClk);
		ring_clk = ~ring_clk;
		wait_tick(EDGE_LATENCY + 2 * (period + 1), cycles, found);
		if (!found) begin
			raise_error({name, ": no sync_tick after the selected ring clock edge"});
		end else if (cycles != EDGE_LATENCY + period + 1) begin
			log_mismatch(name, "first tick after edge", EDGE_LATENCY + period + 1, cycles);
		end
		// later ring edges must not disturb the spacing
		fork
			toggle_ring(8);
			measure_tick_spacing(name, period, 4);
		join
	endtask

	// trigger delay, store window and align phase of one acquisition
	task automatic run_acquisition(input string name, input int idx, input bit inject);
		int c         = 0;
		int ticks     = 0;
		int last_tick = 0;
		int pulses    = 0;
		int p_rise    = -1;
		int p_fall    = -1;
		int s_rise    = -1;
		int s_fall    = -1;
		int a_rise    = -1;
		int a_fall    = -1;
		bit pu_q      = 1'b0;
		bit strb_q    = 1'b0;
		bit al_q      = 1'b0;
		tests_run++;
		@(negedge fastClk);
		trig_delay      = acq_timing_pkg::trig_delay_t'(ACQ_DELAY[idx]);
		sample_hold_off = acq_timing_pkg::hold_off_t'(ACQ_HOLD[idx]);
		num_smpls       = acq_timing_pkg::num_smpls_t'(ACQ_SMPLS[idx]);
		trig            = 1'b1;
		// one pass per falling edge with events logged by cycle
		while (a_fall < 0 && c < acq_cycles(idx)) begin
			@(negedge fastClk);
			c++;
			trig = 1'b0;
			if (adc_powerup === 1'b1 && !pu_q) begin
				p_rise = c;
			end
			if (sync_tick === 1'b1 && p_rise < 0) begin
				ticks++;
				last_tick = c;
			end
			if (adc_powerup !== 1'b1 && pu_q) begin
				p_fall = c;
			end
			if (store_strb === 1'b1 && !strb_q) begin
				s_rise = c;
				pulses++;
				if (state !== acq_timing_pkg::SAMPLING) begin
					log_mismatch(name, "state at strobe", int'(acq_timing_pkg::SAMPLING),
						int'(state));
				end
				// stray trigger in SAMPLING
				trig = inject;
			end
			if (store_strb !== 1'b1 && strb_q) begin
				s_fall = c;
			end
			if (adc_align_en === 1'b1 && !al_q) begin
				a_rise = c;
			end
			if (adc_align_en !== 1'b1 && al_q) begin
				a_fall = c;
			end
			pu_q   = (adc_powerup === 1'b1);
			strb_q = (store_strb === 1'b1);
			al_q   = (adc_align_en === 1'b1);
		end
		if (a_fall < 0 || p_rise < 0 || s_rise < 0 || s_fall < 0 || a_rise < 0) begin
			raise_error({name, ": acquisition did not run through all its phases"});
			return;
		end
		if (ticks != ACQ_DELAY[idx]) begin
			log_mismatch(name, "sync ticks before powerup", ACQ_DELAY[idx], ticks);
		end
		if (p_rise - last_tick != TICK_TO_POWERUP) begin
			log_mismatch(name, "powerup after last tick", TICK_TO_POWERUP, p_rise - last_tick);
		end
		if (s_rise - p_rise != `WARMUP_CYCLES + ACQ_HOLD[idx] + 1) begin
			log_mismatch(name, "strobe rise after powerup",
				`WARMUP_CYCLES + ACQ_HOLD[idx] + 1, s_rise - p_rise);
		end
		if (s_fall - s_rise != ACQ_SMPLS[idx]) begin
			log_mismatch(name, "strobe width", ACQ_SMPLS[idx], s_fall - s_rise);
		end
		if (pulses != 1) begin
			log_mismatch(name, "store_strb pulses", 1, pulses);
		end
		if (a_rise - s_fall != 1) begin
			log_mismatch(name, "align rise after strobe fall", 1, a_rise - s_fall);
		end
		if (a_fall - a_rise != `ALIGN_CYCLES) begin
			log_mismatch(name, "align width", `ALIGN_CYCLES, a_fall - a_rise);
		end
		if (p_fall != a_fall) begin
			log_mismatch(name, "powerup fall cycle", a_fall, p_fall);
		end
		if (state !== acq_timing_pkg::IDLE) begin
			log_mismatch(name, "state after align", int'(acq_timing_pkg::IDLE), int'(state));
		end
	endtask

	task automatic check_trigger_ignored();
		bit woke;
		woke = 1'b0;
		run_acquisition("ignored_trig", 2, 1'b1);
		// a latched stray trigger would restart here
		repeat (4 * (ACQ_SYNC_PERIOD + 1) + 10) begin
			@(negedge fastClk);
			woke = woke || (adc_powerup === 1'b1) || (state !== acq_timing_pkg::IDLE);
		end
		if (woke) begin
			raise_error("ignored_trig: sequencer started again without a new trigger");
		end
		run_acquisition("second_acq", 3, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// watchdog and main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int budget;
		budget = SETUP_CYCLES;
		for (int i = 0; i < NUM_ACQ; i++) begin
			budget += acq_cycles(i);
		end
		budget += budget / 4;
		#(budget * CLK_PERIOD);
		$display("timeout: run still busy after %0d clock cycles", budget);
		$display("Regression failed");
		$finish;
	end

	initial begin
		errors          = 0;
		tests_run       = 0;
		seed            = 32'h3ae973a4;
		arst_n          = 1'b0;
		ring_clk        = 1'b0;
		ring_edge_sel   = 1'b1;
		use_ext_sync    = 1'b0;
		sync_period     = '0;
		trig            = 1'b0;
		trig_delay      = '0;
		sample_hold_off = '0;
		num_smpls       = '0;
		check_reset_state();
		check_ext_sync(1'b1, 4);
		check_ext_sync(1'b0, 11);
		apply_reset(1'b0, 1'b1, ACQ_SYNC_PERIOD);
		run_acquisition("acq_window_a", 0, 1'b0);
		run_acquisition("acq_window_b", 1, 1'b0);
		check_trigger_ignored();
		$display("tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+include
design/acq_timing_pkg.sv
design/ring_clock_sync.sv
design/acq_sequencer.sv
design/store_window.sv
design/acq_timing_top.sv
verif/tb_acq_timing.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_acq_timing
FILELIST   := files.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
